/* filelist.f */
+incdir+hw
hw/cache_types_pkg.sv
hw/host_bus_pkg.sv
hw/cache_tag_store.sv
hw/cache_data_store.sv
hw/cache_host_port.sv
hw/cache_ctrl.sv
hw/cache_subsystem.sv
testbench/cache_properties.sv
testbench/tb_cache_subsystem.sv

/* Makefile */
# Verilator build and run of the cache subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_cache_subsystem
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
FAIL_MSG  := FAIL: see errors above

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG JOBS VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* testbench/tb_cache_subsystem.sv */
`timescale 1ns/1ps

`include "cache_defines.svh"

module tb_cache_subsystem
    import host_bus_pkg::*;
();

    localparam int CLK_PERIOD      = 4;
    localparam int RESET_CYCLES    = 16;
    localparam int CYCLES_PER_TEST = 200;
    localparam int EN_GAP_START    = 3;     // Access cycle where en drops

    localparam logic [1:0] OP_RD   = 2'd0;
    localparam logic [1:0] OP_WR   = 2'd1;
    localparam logic [1:0] OP_BOTH = 2'd2;  // rd and wr together

    logic                   clk = 1'b0;
    logic                   rst_n;
    logic                   en;
    logic                   rd;
    logic                   wr;
    logic [`ADDR_BITS-1:0]  addr;
    logic [`WORD_BITS-1:0]  wdata;
    logic [`WORD_BITS-1:0]  rdata;
    logic                   stall;
    logic                   done;
    logic                   hit;
    host_op_e               host_op;
    logic [`ADDR_BITS-1:0]  host_addr;
    logic [`LINE_BITS-1:0]  host_wline;
    logic [`LINE_BITS-1:0]  host_rline;
    logic                   tx_done_host;

    // Stimulus table
    string                  t_name  [$];
    logic [1:0]             t_op    [$];
    logic [`ADDR_BITS-1:0]  t_addr  [$];
    logic [`WORD_BITS-1:0]  t_wdata [$];
    int                     t_gap   [$];    // Cycles with en held low

    // Host side, real memory and what the host saw
    logic [`WORD_BITS-1:0]  host_mem [logic [`ADDR_BITS-1:0]];
    host_op_e               seen_op   [$];
    logic [`ADDR_BITS-1:0]  seen_addr [$];
    logic [`LINE_BITS-1:0]  seen_line [$];

    // Reference model of memory and cache contents
    logic [`WORD_BITS-1:0]  ref_mem [logic [`ADDR_BITS-1:0]];
    logic [`TAG_BITS-1:0]   ref_tag  [`NUM_SETS];
    logic [`WORD_BITS-1:0]  ref_line [`NUM_SETS][`WORDS_PER_LINE];
    logic [`NUM_SETS-1:0]   ref_valid;
    logic [`NUM_SETS-1:0]   ref_dirty;
    host_op_e               exp_op   [$];
    logic [`ADDR_BITS-1:0]  exp_addr [$];
    logic [`LINE_BITS-1:0]  exp_line [$];

    logic [31:0] lfsr_state = 32'h6358727d;
    int          error_count = 0;
    int          check_count = 0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    cache_subsystem u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .en           (en),
        .rd           (rd),
        .wr           (wr),
        .addr         (addr),
        .wdata        (wdata),
        .rdata        (rdata),
        .stall        (stall),
        .done         (done),
        .hit          (hit),
        .host_op      (host_op),
        .host_addr    (host_addr),
        .host_wline   (host_wline),
        .host_rline   (host_rline),
        .tx_done_host (tx_done_host)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // Host wait of 0 to 7 cycles, one LFSR step per bit
    function automatic int draw_delay();
        int d;
        int k;
        d = 0;
        for (k = 0; k < 3; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            d = (d << 1) | int'(lfsr_state[0]);
        end
        return d;
    endfunction

    function automatic logic [31:0] host_word(input logic [31:0] a);
        return host_mem.exists(a) ? host_mem[a] : '0;
    endfunction

    function automatic logic [31:0] ref_word(input logic [31:0] a);
        return ref_mem.exists(a) ? ref_mem[a] : '0;
    endfunction

    task automatic compare_word(input string sig, input logic [31:0] got,
                                input logic [31:0] exp);
        check_count++;
        assert (got === exp) else begin
            $display("FAILED %s got %h exp %h", sig, got, exp);
            error_count++;
        end
    endtask

    task automatic expect_true(input logic cond, input string what);
        check_count++;
        assert (cond) else begin
            $display("ERROR: %s", what);
            error_count++;
        end
    endtask

    task automatic add_entry(input string name, input logic [1:0] op,
                             input logic [31:0] a, input logic [31:0] wd, input int gap);
        t_name.push_back(name);
        t_op.push_back(op);
        t_addr.push_back(a);
        t_wdata.push_back(wd);
        t_gap.push_back(gap);
    endtask

    // A and B share index 05, C and D share index 21
    task automatic build_table();
        add_entry("cold read",              OP_RD,   32'h0004_8140, 32'h0,          0);
        add_entry("read hit",               OP_RD,   32'h0004_8144, 32'h0,          0);
        add_entry("write hit",              OP_WR,   32'h0004_8148, 32'hCAFE_0001,  0);
        add_entry("read after write",       OP_RD,   32'h0004_8148, 32'h0,          0);
        add_entry("write hit last word",    OP_WR,   32'h0004_817C, 32'h1234_5678,  0);
        add_entry("dirty eviction",         OP_RD,   32'h000D_0148, 32'h0,          0);
        add_entry("write miss allocate",    OP_WR,   32'h0004_8150, 32'hA5A5_0010,  0);
        add_entry("refilled word",          OP_RD,   32'h0004_8148, 32'h0,          0);
        add_entry("refilled last word",     OP_RD,   32'h0004_817C, 32'h0,          0);
        add_entry("merged word",            OP_RD,   32'h0004_8150, 32'h0,          0);
        add_entry("en low write miss",      OP_WR,   32'hC000_4840, 32'h0BAD_F00D, 10);
        add_entry("rd wins over wr",        OP_BOTH, 32'hC000_4844, 32'hFFFF_FFFF,  0);
        add_entry("en low dirty eviction",  OP_RD,   32'h0001_C840, 32'h0,         12);
        add_entry("en low refill",          OP_RD,   32'hC000_4840, 32'h0,          8);
        add_entry("word left unwritten",    OP_RD,   32'hC000_4844, 32'h0,          0);
    endtask

    // Write-back, write-allocate, direct-mapped rules
    task automatic model_access(input logic [1:0] op, input logic [31:0] a,
                                input logic [31:0] wd, output logic exp_hit,
                                output logic [31:0] exp_rdata);
        logic [`TAG_BITS-1:0]       tg;
        logic [`INDEX_BITS-1:0]     idx;
        logic [`WORD_SEL_BITS-1:0]  w;
        logic [31:0]                base;
        logic [`LINE_BITS-1:0]      line;
        int                         i;
        tg      = a[`ADDR_BITS-1:`TAG_LSB];
        idx     = a[`TAG_LSB-1:`INDEX_LSB];
        w       = a[`OFFSET_BITS-1:`BYTE_SEL_BITS];
        exp_hit = ref_valid[idx] && (ref_tag[idx] == tg);
        if (!exp_hit) begin
            if (ref_valid[idx] && ref_dirty[idx]) begin
                base = {ref_tag[idx], idx, {`OFFSET_BITS{1'b0}}};
                for (i = 0; i < `WORDS_PER_LINE; i++) begin
                    line[i*`WORD_BITS +: `WORD_BITS] = ref_line[idx][i];
                    ref_mem[base + 4*i] = ref_line[idx][i];
                end
                exp_op.push_back(WRITE);
                exp_addr.push_back(base);
                exp_line.push_back(line);
            end
            base = {tg, idx, {`OFFSET_BITS{1'b0}}};
            for (i = 0; i < `WORDS_PER_LINE; i++) begin
                ref_line[idx][i] = ref_word(base + 4*i);
            end
            exp_op.push_back(READ);
            exp_addr.push_back(base);
            exp_line.push_back('0);
            ref_valid[idx] = 1'b1;
            ref_tag[idx]   = tg;
            ref_dirty[idx] = 1'b0;
        end
        if (op == OP_WR) begin
            ref_line[idx][w] = wd;
            ref_dirty[idx]   = 1'b1;
        end
        exp_rdata = ref_line[idx][w];
    endtask

    task automatic compare_host_traffic();
        int i;
        int k;
        expect_true(seen_op.size() == exp_op.size(),
            $sformatf("host saw %0d transfers, model expects %0d",
                      seen_op.size(), exp_op.size()));
        if (seen_op.size() == exp_op.size()) begin
            for (i = 0; i < exp_op.size(); i++) begin
                compare_word("host_op", 32'(seen_op[i]), 32'(exp_op[i]));
                compare_word("host_addr", seen_addr[i], exp_addr[i]);
                if (exp_op[i] == WRITE) begin
                    for (k = 0; k < `WORDS_PER_LINE; k++) begin
                        compare_word($sformatf("host_wline[%0d]", k),
                                     seen_line[i][k*`WORD_BITS +: `WORD_BITS],
                                     exp_line[i][k*`WORD_BITS +: `WORD_BITS]);
                    end
                end
            end
        end
    endtask

    task automatic apply_reset();
        int errs_before;
        errs_before = error_count;
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        compare_word("stall", 32'(stall), 32'h0);
        compare_word("done", 32'(done), 32'h0);
        compare_word("hit", 32'(hit), 32'h0);
        compare_word("host_op", 32'(host_op), 32'(NONE));
        $display("test 0 reset state: %s", (error_count == errs_before) ? "ok" : "mismatch");
    endtask

    task automatic run_test(input int n);
        logic        exp_hit;
        logic [31:0] exp_rdata;
        int          cycles;
        int          gap_left;
        int          errs_before;
        logic        saw_done;
        errs_before = error_count;
        seen_op.delete();
        seen_addr.delete();
        seen_line.delete();
        exp_op.delete();
        exp_addr.delete();
        exp_line.delete();
        model_access(t_op[n], t_addr[n], t_wdata[n], exp_hit, exp_rdata);
        @(negedge clk);
        compare_word("stall", 32'(stall), 32'h0);   // Idle before the request
        en       = 1'b1;
        rd       = (t_op[n] != OP_WR);
        wr       = (t_op[n] != OP_RD);
        addr     = t_addr[n];
        wdata    = t_wdata[n];
        cycles   = 0;
        gap_left = 0;
        saw_done = 1'b0;
        while (!saw_done && cycles < CYCLES_PER_TEST) begin
            @(negedge clk);
            cycles++;
            if (!en) begin
                expect_true(stall && !done, "access moved on while en was low");
                gap_left--;
                if (gap_left == 0) begin
                    en = 1'b1;
                end
            end else if (done) begin
                saw_done = 1'b1;
                compare_word("hit", 32'(hit), 32'(exp_hit));
                if (t_op[n] != OP_WR) begin
                    compare_word("rdata", rdata, exp_rdata);
                end
                if (exp_hit) begin
                    expect_true(cycles == 1,
                        $sformatf("hit took %0d cycles instead of 1", cycles));
                end
            end else if (cycles == EN_GAP_START && t_gap[n] > 0) begin
                en       = 1'b0;    // Freeze in the middle of the miss
                gap_left = t_gap[n];
            end
            rd = 1'b0;
            wr = 1'b0;
        end
        en = 1'b1;
        expect_true(saw_done, $sformatf("no done within %0d cycles", CYCLES_PER_TEST));
        compare_host_traffic();
        $display("test %0d %s: %s after %0d cycles", n + 1, t_name[n],
                 (error_count == errs_before) ? "ok" : "mismatch", cycles);
    endtask

    // Host memory controller, answers after a random wait
    initial begin : host_model
        int          delay;
        int          i;
        logic [31:0] base;
        tx_done_host = 1'b0;
        host_rline   = '0;
        forever begin
            @(negedge clk);
            if (rst_n && host_op != NONE) begin
                delay = draw_delay();
                repeat (delay) @(negedge clk);
                base = host_addr;
                seen_op.push_back(host_op);
                seen_addr.push_back(base);
                seen_line.push_back(host_wline);
                for (i = 0; i < `WORDS_PER_LINE; i++) begin
                    if (host_op == WRITE) begin
                        host_mem[base + 4*i] = host_wline[i*`WORD_BITS +: `WORD_BITS];
                    end else begin
                        host_rline[i*`WORD_BITS +: `WORD_BITS] = host_word(base + 4*i);
                    end
                end
                tx_done_host = 1'b1;
                @(negedge clk);
                tx_done_host = 1'b0;
            end
        end
    end

    initial begin : watchdog
        int limit;
        #1;
        limit = (RESET_CYCLES + CYCLES_PER_TEST * t_name.size()) * CLK_PERIOD;
        #(limit);
        $display("ERROR: watchdog expired after %0d ns, an access never finished", limit);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin : main
        int n;
        en        = 1'b0;
        rd        = 1'b0;
        wr        = 1'b0;
        addr      = '0;
        wdata     = '0;
        ref_valid = '0;
        ref_dirty = '0;
        build_table();
        apply_reset();
        for (n = 0; n < t_name.size(); n++) begin
            run_test(n);
        end
        $display("tests %0d  checks %0d  errors %0d", t_name.size(), check_count, error_count);
        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* testbench/cache_properties.sv */
`timescale 1ns/1ps

`include "cache_defines.svh"

module cache_properties
    import cache_types_pkg::*;
    import host_bus_pkg::*;
(
    input logic                     clk,
    input logic                     rst_n,
    input ctrl_state_e              state,
    input logic                     stall,
    input logic                     done,
    input host_op_e                 host_op,
    input logic [`ADDR_BITS-1:0]    host_addr,
    input logic [`LINE_BITS-1:0]    host_wline,
    input logic                     tx_done_host
);

    // One done cycle per access
    done_single: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
        else $error("done high for two cycles in a row");

    // Idle controller leaves the host bus quiet
    stall_idle: assert property (@(posedge clk) disable iff (!rst_n)
        (state == IDLE) |-> (!stall && host_op == NONE))
        else $error("stall or host request active while the controller is idle");

    // Request held until the host finishes
    host_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (host_op != NONE && !tx_done_host) |=>
            ($stable(host_op) && $stable(host_addr) && $stable(host_wline)))
        else $error("host request changed before tx_done_host");

endmodule

bind cache_subsystem cache_properties u_props (
    .clk          (clk),
    .rst_n        (rst_n),
    .state        (u_ctrl.state),
    .stall        (u_ctrl.stall),
    .done         (u_ctrl.done),
    .host_op      (u_host.host_op),
    .host_addr    (u_host.host_addr),
    .host_wline   (u_host.host_wline),
    .tx_done_host (u_host.tx_done_host)
);

/* hw/cache_subsystem.sv */
`timescale 1ns/1ps

`include "cache_defines.svh"

module cache_subsystem
    import host_bus_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    // CPU side
    input  logic                    en,
    input  logic                    rd,
    input  logic                    wr,
    input  logic [`ADDR_BITS-1:0]   addr,
    input  logic [`WORD_BITS-1:0]   wdata,
    output logic [`WORD_BITS-1:0]   rdata,
    output logic                    stall,
    output logic                    done,
    output logic                    hit,
    // Host side
    output host_op_e                host_op,
    output logic [`ADDR_BITS-1:0]   host_addr,
    output logic [`LINE_BITS-1:0]   host_wline,
    input  logic [`LINE_BITS-1:0]   host_rline,
    input  logic                    tx_done_host
);

    logic                       tag_hit;
    logic                       line_valid;
    logic                       line_dirty;
    logic [`TAG_BITS-1:0]       victim_tag;
    logic [`WORD_BITS-1:0]      rd_word;
    logic [`LINE_BITS-1:0]      victim_line;
    logic [`INDEX_BITS-1:0]     index;
    logic [`TAG_BITS-1:0]       tag;
    logic [`WORD_SEL_BITS-1:0]  word_sel;
    logic                       wr_word;
    logic [`WORD_BITS-1:0]      word_data;
    logic                       replace_line;
    logic                       set_dirty;
    logic                       install;
    logic                       install_dirty;
    logic                       start_wb;
    logic                       start_fill;
    logic [`LINE_BITS-1:0]      fill_line;
    logic                       xfer_done;

    cache_ctrl u_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .en            (en),
        .rd            (rd),
        .wr            (wr),
        .addr          (addr),
        .wdata         (wdata),
        .tag_hit       (tag_hit),
        .line_valid    (line_valid),
        .line_dirty    (line_dirty),
        .rd_word       (rd_word),
        .xfer_done     (xfer_done),
        .rdata         (rdata),
        .stall         (stall),
        .done          (done),
        .hit           (hit),
        .index         (index),
        .tag           (tag),
        .word_sel      (word_sel),
        .wr_word       (wr_word),
        .word_data     (word_data),
        .replace_line  (replace_line),
        .set_dirty     (set_dirty),
        .install       (install),
        .install_dirty (install_dirty),
        .start_wb      (start_wb),
        .start_fill    (start_fill)
    );

    cache_tag_store u_tags (
        .clk           (clk),
        .rst_n         (rst_n),
        .index         (index),
        .tag           (tag),
        .install       (install),
        .install_dirty (install_dirty),
        .set_dirty     (set_dirty),
        .tag_hit       (tag_hit),
        .line_valid    (line_valid),
        .line_dirty    (line_dirty),
        .victim_tag    (victim_tag)
    );

    cache_data_store u_data (
        .clk           (clk),
        .index         (index),
        .word_sel      (word_sel),
        .wr_word       (wr_word),
        .word_data     (word_data),
        .replace_line  (replace_line),
        .fill_line     (fill_line),
        .rd_word       (rd_word),
        .victim_line   (victim_line)
    );

    cache_host_port u_host (
        .clk           (clk),
        .rst_n         (rst_n),
        .start_wb      (start_wb),
        .start_fill    (start_fill),
        .index         (index),
        .tag           (tag),
        .victim_tag    (victim_tag),
        .victim_line   (victim_line),
        .host_rline    (host_rline),
        .tx_done_host  (tx_done_host),
        .host_op       (host_op),
        .host_addr     (host_addr),
        .host_wline    (host_wline),
        .fill_line     (fill_line),
        .xfer_done     (xfer_done)
    );

endmodule

/* hw/cache_ctrl.sv */
`timescale 1ns/1ps

`include "cache_defines.svh"

module cache_ctrl
    import cache_types_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        en,
    input  logic                        rd,
    input  logic                        wr,
    input  logic [`ADDR_BITS-1:0]       addr,
    input  logic [`WORD_BITS-1:0]       wdata,
    input  logic                        tag_hit,
    input  logic                        line_valid,
    input  logic                        line_dirty,
    input  logic [`WORD_BITS-1:0]       rd_word,
    input  logic                        xfer_done,
    output logic [`WORD_BITS-1:0]       rdata,
    output logic                        stall,
    output logic                        done,
    output logic                        hit,
    output logic [`INDEX_BITS-1:0]      index,
    output logic [`TAG_BITS-1:0]        tag,
    output logic [`WORD_SEL_BITS-1:0]   word_sel,
    output logic                        wr_word,
    output logic [`WORD_BITS-1:0]       word_data,
    output logic                        replace_line,
    output logic                        set_dirty,
    output logic                        install,
    output logic                        install_dirty,
    output logic                        start_wb,
    output logic                        start_fill
);

    ctrl_state_e state, next_state;

    cache_addr_u              req_addr;
    logic [`WORD_BITS-1:0]    req_wdata;
    logic                     req_read;
    logic                     missed;     // First compare of this access missed
    logic                     xfer_pend;  // Host finished while en was low
    logic                     xfer;
    logic                     victim_dirty;

    // Request is captured once, when it is accepted
    always_ff @(posedge clk) begin
        if (state == IDLE && en && (rd || wr)) begin
            req_addr  <= addr;
            req_wdata <= wdata;
            req_read  <= rd;   // Read wins over write
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else if (en) begin
            state <= next_state;
        end
    end

    // Keep a host completion that arrives while frozen
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            xfer_pend <= 1'b0;
        end else if (en) begin
            xfer_pend <= 1'b0;
        end else if (xfer_done) begin
            xfer_pend <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            missed <= 1'b0;
        end else if (en) begin
            if (state == IDLE) begin
                missed <= 1'b0;
            end else if ((state == CMPRD || state == CMPWR) && !tag_hit) begin
                missed <= 1'b1;
            end
        end
    end

    assign xfer         = xfer_done || xfer_pend;
    assign victim_dirty = line_valid && line_dirty;

    always_comb begin
        next_state   = state;
        done         = 1'b0;
        wr_word      = 1'b0;
        set_dirty    = 1'b0;
        replace_line = 1'b0;
        install      = 1'b0;
        start_wb     = 1'b0;
        start_fill   = 1'b0;
        case (state)
            IDLE: begin
                if (en && rd) begin
                    next_state = CMPRD;
                end else if (en && wr) begin
                    next_state = CMPWR;
                end
            end
            CMPRD, CMPWR: begin
                if (tag_hit) begin
                    done       = en;
                    wr_word    = en && (state == CMPWR);
                    set_dirty  = en && (state == CMPWR);
                    next_state = IDLE;
                end else if (victim_dirty) begin
                    start_wb   = en;  // Evict before refill
                    next_state = MEMWB;
                end else begin
                    start_fill = en;
                    next_state = MEMRD;
                end
            end
            MEMWB: begin
                if (xfer) begin
                    start_fill = en;
                    next_state = MEMRD;
                end
            end
            MEMRD: begin
                if (xfer) begin
                    replace_line = en;
                    install      = en;
                    // Reads go back to compare and hit there
                    next_state   = req_read ? CMPRD : CACHEWR;
                end
            end
            CACHEWR: begin
                wr_word    = en;  // Merge the word into the new line
                set_dirty  = en;
                done       = en;
                next_state = IDLE;
            end
            default: next_state = IDLE;
        endcase
    end

    assign stall         = (state != IDLE);
    assign hit           = done && !missed;
    assign rdata         = (state == CMPRD) ? rd_word : '0;
    assign install_dirty = 1'b0;  // Fresh lines match host memory
    assign index         = req_addr.fields.index;
    assign tag           = req_addr.fields.tag;
    assign word_sel      = req_addr.fields.offset[`OFFSET_BITS-1:`BYTE_SEL_BITS];
    assign word_data     = req_wdata;

endmodule

/* hw/cache_host_port.sv */
`timescale 1ns/1ps

`include "cache_defines.svh"

module cache_host_port
    import cache_types_pkg::*;
    import host_bus_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        start_wb,
    input  logic                        start_fill,
    input  logic [`INDEX_BITS-1:0]      index,
    input  logic [`TAG_BITS-1:0]        tag,
    input  logic [`TAG_BITS-1:0]        victim_tag,
    input  logic [`LINE_BITS-1:0]       victim_line,
    input  logic [`LINE_BITS-1:0]       host_rline,
    input  logic                        tx_done_host,
    output host_op_e                    host_op,
    output logic [`ADDR_BITS-1:0]       host_addr,
    output logic [`LINE_BITS-1:0]       host_wline,
    output logic [`LINE_BITS-1:0]       fill_line,
    output logic                        xfer_done
);

    cache_addr_u wb_addr;
    cache_addr_u fill_addr;
    logic        finish;

    // Line-aligned addresses, offset always zero
    always_comb begin
        wb_addr.line.line_num   = {victim_tag, index};
        wb_addr.line.offset     = '0;
        fill_addr.line.line_num = {tag, index};
        fill_addr.line.offset   = '0;
    end

    // Ignore a stray completion on an idle bus
    assign finish = tx_done_host && host_op_active(host_op);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            host_op   <= NONE;
            xfer_done <= 1'b0;
        end else begin
            xfer_done <= finish;
            if (finish) begin
                host_op <= NONE;
            end else if (start_wb) begin
                host_op <= WRITE;
            end else if (start_fill) begin
                host_op <= READ;
            end
        end
    end

    // Payload held stable for the whole transfer
    always_ff @(posedge clk) begin
        if (start_wb) begin
            host_addr  <= wb_addr;
            host_wline <= victim_line;
        end else if (start_fill) begin
            host_addr  <= fill_addr;
        end
        if (finish && !host_op_is_write(host_op)) begin
            fill_line <= host_rline;   // Valid only with tx_done_host
        end
    end

endmodule

/* hw/cache_data_store.sv */
`timescale 1ns/1ps

`include "cache_defines.svh"

module cache_data_store (
    input  logic                        clk,
    input  logic [`INDEX_BITS-1:0]      index,
    input  logic [`WORD_SEL_BITS-1:0]   word_sel,
    input  logic                        wr_word,
    input  logic [`WORD_BITS-1:0]       word_data,
    input  logic                        replace_line,
    input  logic [`LINE_BITS-1:0]       fill_line,
    output logic [`WORD_BITS-1:0]       rd_word,
    output logic [`LINE_BITS-1:0]       victim_line
);

    logic [`LINE_BITS-1:0] lines [`NUM_SETS];

    // A refill replaces the whole line, otherwise one word may change
    always_ff @(posedge clk) begin
        if (replace_line) begin
            lines[index] <= fill_line;
        end else if (wr_word) begin
            lines[index][word_sel*`WORD_BITS +: `WORD_BITS] <= word_data;
        end
    end

    assign victim_line = lines[index];                              // Full line for writeback
    assign rd_word     = victim_line[word_sel*`WORD_BITS +: `WORD_BITS];

endmodule

/* hw/cache_tag_store.sv */
`timescale 1ns/1ps

`include "cache_defines.svh"

module cache_tag_store (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [`INDEX_BITS-1:0]  index,
    input  logic [`TAG_BITS-1:0]    tag,
    input  logic                    install,
    input  logic                    install_dirty,
    input  logic                    set_dirty,
    output logic                    tag_hit,
    output logic                    line_valid,
    output logic                    line_dirty,
    output logic [`TAG_BITS-1:0]    victim_tag
);

    logic [`TAG_BITS-1:0] tags [`NUM_SETS];
    logic [`NUM_SETS-1:0] valid;
    logic [`NUM_SETS-1:0] dirty;

    // Tag written when a line is installed
    always_ff @(posedge clk) begin
        if (install) begin
            tags[index] <= tag;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= '0;
            dirty <= '0;
        end else begin
            if (install) begin
                valid[index] <= 1'b1;
                dirty[index] <= install_dirty;
            end else if (set_dirty) begin
                dirty[index] <= 1'b1;  // Word write on a resident line
            end
        end
    end

    // Lookup is combinational
    assign line_valid = valid[index];
    assign line_dirty = dirty[index];
    assign victim_tag = tags[index];
    assign tag_hit    = line_valid && (victim_tag == tag);

endmodule

/* hw/host_bus_pkg.sv */
package host_bus_pkg;

    // Operation code on the host memory controller port
    typedef enum logic [1:0] {
        NONE  = 2'b00,  // Idle bus
        READ  = 2'b01,  // Line fill
        WRITE = 2'b11   // Line writeback
    } host_op_e;

    // Bit 0 marks any active transfer
    function automatic logic host_op_active(input host_op_e op);
        logic active;
        active = (op != NONE);
        return active;
    endfunction

    // Bit 1 separates writebacks from fills
    function automatic logic host_op_is_write(input host_op_e op);
        logic is_wr;
        is_wr = (op == WRITE);
        return is_wr;
    endfunction

endpackage

/* hw/cache_types_pkg.sv */
package cache_types_pkg;

    `include "cache_defines.svh"

    // Cache store view of an address
    typedef struct packed {
        logic [`TAG_BITS-1:0]    tag;
        logic [`INDEX_BITS-1:0]  index;
        logic [`OFFSET_BITS-1:0] offset;
    } cache_addr_fields_t;

    // Host view as line number and offset
    typedef struct packed {
        logic [`LINE_NUM_BITS-1:0] line_num;
        logic [`OFFSET_BITS-1:0]   offset;
    } cache_addr_line_t;

    typedef union packed {
        cache_addr_fields_t fields;
        cache_addr_line_t   line;
    } cache_addr_u;

    // Controller states
    typedef enum logic [2:0] {
        IDLE    = 3'd0,
        CMPRD   = 3'd1,
        MEMWB   = 3'd2,
        MEMRD   = 3'd3,
        CACHEWR = 3'd4,
        CMPWR   = 3'd5
    } ctrl_state_e;

endpackage

/* hw/cache_defines.svh */
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// Data widths
`define WORD_BITS       32
`define LINE_BITS       512
`define ADDR_BITS       32
`define WORDS_PER_LINE  16

// Address split, tag | index | offset
`define TAG_BITS        18
`define INDEX_BITS      8
`define OFFSET_BITS     6
`define NUM_SETS        256

// Offset split into word select and ignored byte bits
`define WORD_SEL_BITS   4
`define BYTE_SEL_BITS   2

// Line number used for line-aligned host addresses
`define LINE_NUM_BITS   (`ADDR_BITS - `OFFSET_BITS)

// Tag field position inside an address
`define TAG_LSB         (`INDEX_BITS + `OFFSET_BITS)
`define INDEX_LSB       `OFFSET_BITS

`endif
